// ==== verilog/frame_pkg.sv ====
// Shared widths, FSM codes, entry and result types for the frame streaming blocks; import it.
package frame_pkg;

   localparam int FIFO_DEPTH_W = 3;
   localparam int FIFO_DEPTH   = 2 ** FIFO_DEPTH_W;
   localparam int TAG_W        = 3;
   localparam int LEN_W        = 5;
   localparam int BYTE_W       = 8;
   localparam int CNT_W        = LEN_W + 1; // Holds 32.

   localparam logic [1:0] BLD_IDLE    = 2'd0;
   localparam logic [1:0] BLD_HDR     = 2'd1;
   localparam logic [1:0] BLD_PAYLOAD = 2'd2;

   typedef struct packed {
      logic [TAG_W-1:0] tag;
      logic [LEN_W-1:0] len;
   } frame_cmd_t;

   typedef struct packed {
      logic [TAG_W-1:0] tag;
      logic [LEN_W-1:0] len;
   } frame_hdr_t;

   typedef struct packed {
      logic [BYTE_W-1:0] data;
   } frame_body_t;

   // One entry word, seen as a header or as a payload byte.
   typedef union packed {
      frame_hdr_t  hdr;
      frame_body_t body;
   } entry_word_u;

   typedef struct packed {
      logic        is_hdr;
      entry_word_u word;
   } fifo_entry_t;

   typedef struct packed {
      logic [TAG_W-1:0]  tag;
      logic [LEN_W-1:0]  len;
      logic [BYTE_W-1:0] sum;
   } frame_res_t;

   // Length field to byte count, 0 stands for 32.
   function automatic logic [CNT_W-1:0] frame_count(input logic [LEN_W-1:0] len);
      if (len == '0) begin
         frame_count = CNT_W'(2 ** LEN_W);
      end else begin
         frame_count = CNT_W'(len);
      end
   endfunction

endpackage

// ==== verilog/frame_builder.sv ====
// Frame producer; takes a command and its payload bytes and emits a header then data entries.
module frame_builder
   import frame_pkg::*;
(
   input  logic              clk,
   input  logic              nrst,
   input  frame_cmd_t        cmd,
   input  logic              cmd_valid,
   output logic              cmd_ready,
   input  logic [BYTE_W-1:0] in_data,
   input  logic              in_valid,
   output logic              in_ready,
   output fifo_entry_t       push_entry,
   output logic              push_valid,
   input  logic              push_ready
);

   logic [1:0]       state;
   frame_hdr_t       hdr_q;
   logic [CNT_W-1:0] cnt;
   logic             cmd_fire;
   logic             byte_fire;

   assign cmd_fire  = cmd_valid & cmd_ready;
   assign byte_fire = in_valid & in_ready;

   always_comb begin
      cmd_ready  = 1'b0;
      in_ready   = 1'b0;
      push_valid = 1'b0;
      push_entry = '0;
      case (state)
         BLD_IDLE: begin
            cmd_ready = 1'b1;
         end
         BLD_HDR: begin
            push_valid            = 1'b1;
            push_entry.is_hdr     = 1'b1;
            push_entry.word.hdr   = hdr_q;
         end
         BLD_PAYLOAD: begin
            in_ready                  = push_ready; // Bytes pass straight into the FIFO.
            push_valid                = in_valid;
            push_entry.word.body.data = in_data;
         end
         default: begin
            cmd_ready = 1'b0;
         end
      endcase
   end

   // Command register, held for the header.
   always_ff @(posedge clk) begin
      if (cmd_fire) begin
         hdr_q.tag <= cmd.tag;
         hdr_q.len <= cmd.len;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         state <= BLD_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            BLD_IDLE: begin
               if (cmd_fire) begin
                  cnt   <= frame_count(cmd.len);
                  state <= BLD_HDR;
               end
            end
            BLD_HDR: begin
               if (push_ready) begin
                  state <= BLD_PAYLOAD; // Header taken by the FIFO.
               end
            end
            BLD_PAYLOAD: begin
               if (byte_fire) begin
                  cnt <= cnt - 1'b1;
                  if (cnt == CNT_W'(1)) begin
                     state <= BLD_IDLE; // Last byte of the frame.
                  end
               end
            end
            default: begin
               state <= BLD_IDLE;
            end
         endcase
      end
   end

endmodule

// ==== verilog/stream_fifo.sv ====
// Circular entry buffer with valid/ready on both sides and a show-ahead output.
module stream_fifo
   import frame_pkg::*;
(
   input  logic        clk,
   input  logic        nrst,
   input  fifo_entry_t push_entry,
   input  logic        push_valid,
   output logic        push_ready,
   output fifo_entry_t pop_entry,
   output logic        pop_valid,
   input  logic        pop_ready
);

   fifo_entry_t             mem [FIFO_DEPTH];
   logic [FIFO_DEPTH_W-1:0] rd_ptr;
   logic [FIFO_DEPTH_W-1:0] wr_ptr;
   logic                    full;
   logic                    push_fire;
   logic                    pop_fire;

   assign push_ready = ~full;
   assign pop_valid  = (wr_ptr != rd_ptr) | full; // Equal pointers mean empty unless full.
   assign pop_entry  = mem[rd_ptr];
   assign push_fire  = push_valid & push_ready;
   assign pop_fire   = pop_valid & pop_ready;

   always_ff @(posedge clk) begin
      if (push_fire) begin
         mem[wr_ptr] <= push_entry;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
      end else begin
         if (push_fire) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_fire) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         full <= 1'b0;
      end else begin
         case ({push_fire, pop_fire})
            2'b01: begin
               full <= 1'b0; // Any pop alone frees a slot.
            end
            2'b10: begin
               if (FIFO_DEPTH_W'(wr_ptr + 1'b1) == rd_ptr) begin
                  full <= 1'b1;
               end
            end
            default: begin
               full <= full;
            end
         endcase
      end
   end

endmodule

// ==== verilog/frame_checker.sv ====
// Frame consumer; decodes FIFO entries and returns tag, length and payload sum per frame.
module frame_checker
   import frame_pkg::*;
(
   input  logic        clk,
   input  logic        nrst,
   input  fifo_entry_t pop_entry,
   input  logic        pop_valid,
   output logic        pop_ready,
   output frame_res_t  res,
   output logic        res_valid,
   input  logic        res_ready
);

   logic [TAG_W-1:0]  tag_q;
   logic [LEN_W-1:0]  len_q;
   logic [BYTE_W-1:0] sum_q;
   logic [BYTE_W-1:0] sum_next;
   logic [CNT_W-1:0]  remain;
   logic              pop_fire;
   logic              last_byte;
   frame_res_t        res_q;

   assign pop_ready = ~res_valid; // Stall while a result waits.
   assign pop_fire  = pop_valid & pop_ready;
   assign sum_next  = sum_q + pop_entry.word.body.data; // Wraps modulo 256.
   assign last_byte = pop_fire & ~pop_entry.is_hdr & (remain == CNT_W'(1));
   assign res       = res_q;

   // Frame fields and running sum.
   always_ff @(posedge clk) begin
      if (pop_fire) begin
         if (pop_entry.is_hdr) begin
            tag_q <= pop_entry.word.hdr.tag;
            len_q <= pop_entry.word.hdr.len;
            sum_q <= '0;
         end else begin
            sum_q <= sum_next;
         end
      end
      if (last_byte) begin
         res_q.tag <= tag_q;
         res_q.len <= len_q;
         res_q.sum <= sum_next;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         remain <= '0;
      end else if (pop_fire) begin
         if (pop_entry.is_hdr) begin
            remain <= frame_count(pop_entry.word.hdr.len);
         end else if (remain != '0) begin
            remain <= remain - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         res_valid <= 1'b0;
      end else if (last_byte) begin
         res_valid <= 1'b1;
      end else if (res_ready) begin
         res_valid <= 1'b0; // Result accepted.
      end
   end

endmodule

// ==== verilog/frame_top.sv ====
// Top of the frame stream; builder feeds the buffer FIFO, which feeds the checker.
module frame_top
   import frame_pkg::*;
(
   input  logic              clk,
   input  logic              nrst,
   input  frame_cmd_t        cmd,
   input  logic              cmd_valid,
   output logic              cmd_ready,
   input  logic [BYTE_W-1:0] in_data,
   input  logic              in_valid,
   output logic              in_ready,
   output frame_res_t        res,
   output logic              res_valid,
   input  logic              res_ready
);

   fifo_entry_t push_entry;
   logic        push_valid;
   logic        push_ready;
   fifo_entry_t pop_entry;
   logic        pop_valid;
   logic        pop_ready;

   frame_builder i_frame_builder (
      .clk        (clk),
      .nrst       (nrst),
      .cmd        (cmd),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .in_data    (in_data),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .push_entry (push_entry),
      .push_valid (push_valid),
      .push_ready (push_ready)
   );

   stream_fifo i_stream_fifo (
      .clk        (clk),
      .nrst       (nrst),
      .push_entry (push_entry),
      .push_valid (push_valid),
      .push_ready (push_ready),
      .pop_entry  (pop_entry),
      .pop_valid  (pop_valid),
      .pop_ready  (pop_ready)
   );

   frame_checker i_frame_checker (
      .clk       (clk),
      .nrst      (nrst),
      .pop_entry (pop_entry),
      .pop_valid (pop_valid),
      .pop_ready (pop_ready),
      .res       (res),
      .res_valid (res_valid),
      .res_ready (res_ready)
   );

endmodule

// ==== testbench/frame_assert.sv ====
// Handshake checks on the buffer FIFO, attached to every stream_fifo instance by bind.
module frame_assert
   import frame_pkg::*;
(
   input logic        clk,
   input logic        nrst,
   input fifo_entry_t push_entry,
   input logic        push_valid,
   input logic        push_ready,
   input fifo_entry_t pop_entry,
   input logic        pop_valid,
   input logic        pop_ready
);

   int fail_count = 0; // Failed assertions so far.

   property empty_after_reset;
      @(posedge clk) nrst |=> !pop_valid;
   endproperty

   // A refused entry stays offered until the FIFO takes it.
   property no_push_when_full;
      @(posedge clk) disable iff (nrst)
         (push_valid && !push_ready) |=> push_valid && $stable(push_entry);
   endproperty

   property pop_entry_stable;
      @(posedge clk) disable iff (nrst)
         (pop_valid && !pop_ready) |=> pop_entry == $past(pop_entry);
   endproperty

   a_empty_after_reset: assert property (empty_after_reset)
      else begin
         $error("pop_valid high in the cycle after reset");
         fail_count++;
      end
   a_no_push_when_full: assert property (no_push_when_full)
      else begin
         $error("push entry dropped while push_ready was low");
         fail_count++;
      end
   a_pop_entry_stable: assert property (pop_entry_stable)
      else begin
         $error("pop_entry changed while stalled");
         fail_count++;
      end

endmodule

bind stream_fifo frame_assert i_frame_assert (
   .clk        (clk),
   .nrst       (nrst),
   .push_entry (push_entry),
   .push_valid (push_valid),
   .push_ready (push_ready),
   .pop_entry  (pop_entry),
   .pop_valid  (pop_valid),
   .pop_ready  (pop_ready)
);

// ==== testbench/frame_tb.sv ====
// Testbench for frame_top; sends random frames and checks each result against a queue model.
module frame_tb
   import frame_pkg::*;
();

   localparam int N_RANDOM        = 20;
   localparam int N_BACKPRESS     = 10;
   localparam int TOTAL_BYTES     = 3 + (N_RANDOM + N_BACKPRESS) * 32 + 34 + 14;
   localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 20 + 1000;

   logic              clk;
   logic              nrst;
   frame_cmd_t        cmd;
   logic              cmd_valid;
   logic              cmd_ready;
   logic [BYTE_W-1:0] in_data;
   logic              in_valid;
   logic              in_ready;
   frame_res_t        res;
   logic              res_valid;
   logic              res_ready;

   frame_res_t model_q [$];
   int         errors;
   int         checks;
   int         tests_passed;
   int         tests_failed;
   int         test_start;
   int         assert_seen;
   logic       mid_in_ready; // Cleared when in_ready drops inside a frame.

   frame_top i_frame_top (
      .clk       (clk),
      .nrst      (nrst),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .in_data   (in_data),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .res       (res),
      .res_valid (res_valid),
      .res_ready (res_ready)
   );

   always #2 clk = ~clk;

   function automatic int byte_count(input logic [LEN_W-1:0] len);
      return (len == '0) ? 32 : int'(len); // Field 0 is a full 32 byte frame.
   endfunction

   task automatic compare_res(input frame_res_t got, input frame_res_t exp);
      checks++;
      if (got !== exp) begin
         $display("[FAIL] res got 0x%h (tag 0x%h len 0x%h sum 0x%h) expected 0x%h",
                  got, got.tag, got.len, got.sum, exp);
         errors++;
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic apply_reset();
      cmd_valid <= 1'b0;
      in_valid  <= 1'b0;
      nrst      <= 1'b1;
      model_q.delete();
      repeat (3) @(posedge clk);
      nrst <= 1'b0;
   endtask

   task automatic idle_gap(input int gap_max);
      int gap;
      gap = (gap_max > 0) ? $urandom_range(gap_max) : 0;
      if (gap > 0) begin
         in_valid <= 1'b0;
         repeat (gap) @(posedge clk);
      end
   endtask

   // Generates the payload, logs the expected result, then drives up to max_bytes bytes.
   task automatic send_frame(input logic [TAG_W-1:0] tag, input logic [LEN_W-1:0] len,
                             input int gap_max, input int max_bytes);
      logic [BYTE_W-1:0] data [$];
      logic [BYTE_W-1:0] sum;
      frame_res_t        exp;
      int                i;
      int                n;
      sum = '0;
      for (i = 0; i < byte_count(len); i++) begin
         data.push_back(BYTE_W'($urandom));
         sum = sum + data[i];
      end
      exp.tag = tag;
      exp.len = len;
      exp.sum = sum;
      model_q.push_back(exp);
      n = (max_bytes < data.size()) ? max_bytes : data.size();
      idle_gap(gap_max);
      cmd.tag   <= tag;
      cmd.len   <= len;
      cmd_valid <= 1'b1;
      do @(posedge clk); while (!cmd_ready);
      cmd_valid <= 1'b0;
      for (i = 0; i < n; i++) begin
         idle_gap(gap_max);
         in_data  <= data[i];
         in_valid <= 1'b1;
         do begin
            @(posedge clk);
            if (!in_ready && i > 0) mid_in_ready = 1'b0;
         end while (!in_ready);
      end
      in_valid <= 1'b0;
   endtask

   task automatic send_random_frames(input int n, input int gap_max, input int zero_at);
      logic [TAG_W-1:0] tag;
      logic [LEN_W-1:0] len;
      int               k;
      for (k = 0; k < n; k++) begin
         tag = TAG_W'($urandom);
         len = (k == zero_at) ? '0 : LEN_W'($urandom);
         send_frame(tag, len, gap_max, 32);
      end
   endtask

   // Takes n results, holding res_ready low bp_pct percent of the cycles.
   task automatic collect_results(input int n, input int bp_pct);
      int got;
      got = 0;
      res_ready <= ($urandom_range(99) >= bp_pct);
      while (got < n) begin
         @(posedge clk);
         if (res_valid && res_ready) begin
            if (model_q.size() == 0) begin
               $display("Result 0x%h arrived with no frame left in the model", res);
               errors++;
            end else begin
               compare_res(res, model_q.pop_front());
            end
            got++;
         end
         res_ready <= (got == n) ? 1'b1 : ($urandom_range(99) >= bp_pct);
      end
   endtask

   task automatic end_test(input string name);
      int fails;
      fails = i_frame_top.i_stream_fifo.i_frame_assert.fail_count - assert_seen;
      if (fails > 0) begin
         $display("%0d FIFO assertions failed during the test", fails);
         errors      = errors + fails;
         assert_seen = assert_seen + fails;
      end
      if (model_q.size() != 0) begin
         $display("%0d expected results never arrived", model_q.size());
         errors++;
         model_q.delete();
      end
      if (errors == test_start) begin
         tests_passed++;
         $display("Test %s: ok", name);
      end else begin
         tests_failed++;
         $display("Test %s: %0d errors", name, errors - test_start);
      end
      test_start = errors;
   endtask

   initial begin
      int   waited;
      logic extra;
      clk          = 1'b0;
      nrst         = 1'b1;
      cmd          = '0;
      cmd_valid    = 1'b0;
      in_data      = '0;
      in_valid     = 1'b0;
      res_ready    = 1'b0;
      errors       = 0;
      checks       = 0;
      tests_passed = 0;
      tests_failed = 0;
      test_start   = 0;
      assert_seen  = 0;
      mid_in_ready = 1'b1;
      void'($urandom(27));
      apply_reset();

      @(posedge clk);
      compare_bit("cmd_ready", cmd_ready, 1'b1);
      compare_bit("res_valid", res_valid, 1'b0);
      compare_bit("in_ready", in_ready, 1'b0);
      end_test("1 reset state");

      fork
         send_frame(3'd5, 5'd3, 0, 32);
         collect_results(1, 0);
      join
      end_test("2 single frame");

      fork
         send_random_frames(N_RANDOM, 3, 2);
         collect_results(N_RANDOM, 0);
      join
      end_test("3 random frames with gaps");

      fork
         send_random_frames(N_BACKPRESS, 0, -1);
         collect_results(N_BACKPRESS, 50);
      join
      end_test("4 result back-pressure");

      // A pending result stalls the checker, so the long frame fills the FIFO.
      res_ready    <= 1'b0;
      mid_in_ready = 1'b1;
      fork
         begin
            send_frame(3'd2, 5'd2, 0, 32);
            send_frame(3'd3, 5'd0, 0, 32);
         end
         begin
            waited = 0;
            while (mid_in_ready && waited < 400) begin
               @(posedge clk);
               waited++;
            end
            compare_bit("in_ready", mid_in_ready, 1'b0);
            collect_results(2, 0);
         end
      join
      end_test("5 full FIFO stall");

      send_frame(3'd6, 5'd10, 0, 4);
      apply_reset();
      @(posedge clk);
      compare_bit("cmd_ready", cmd_ready, 1'b1);
      fork
         send_frame(3'd1, 5'd4, 0, 32);
         collect_results(1, 0);
      join
      extra = 1'b0;
      repeat (40) begin
         @(posedge clk);
         if (res_valid) extra = 1'b1;
      end
      if (extra) begin
         $display("An extra result appeared after the fresh frame");
         errors++;
      end
      end_test("6 reset mid-frame");

      $display("Tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
               tests_passed + tests_failed, tests_passed, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
      $display("Some tests failed");
      $finish;
   end

endmodule

// ==== all.f ====
verilog/frame_pkg.sv
verilog/frame_builder.sv
verilog/stream_fifo.sv
verilog/frame_checker.sv
verilog/frame_top.sv
testbench/frame_assert.sv
testbench/frame_tb.sv

// ==== Bender.yml ====
package:
  name: frame_stream

sources:
  - files:
      - verilog/frame_pkg.sv
      - verilog/frame_builder.sv
      - verilog/stream_fifo.sv
      - verilog/frame_checker.sv
      - verilog/frame_top.sv
  - target: test
    files:
      - testbench/frame_assert.sv
      - testbench/frame_tb.sv
